/* compile.f */
hw/i2c_pkg.sv
hw/sensor_pkg.sv
hw/scl_timer.sv
hw/bit_engine.sv
hw/byte_engine.sv
hw/fifo_sequencer.sv
hw/sample_assembler.sv
hw/sensor_reader_top.sv
tb/sensor_model.sv
tb/tb_sensor_reader.sv

/* Bender.yml */
package:
  name: sensor_reader

sources:
  - hw/i2c_pkg.sv
  - hw/sensor_pkg.sv
  - hw/scl_timer.sv
  - hw/bit_engine.sv
  - hw/byte_engine.sv
  - hw/fifo_sequencer.sv
  - hw/sample_assembler.sv
  - hw/sensor_reader_top.sv
  - target: test
    files:
      - tb/sensor_model.sv
      - tb/tb_sensor_reader.sv

/* tb/tb_sensor_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_reader;
    import i2c_pkg::*;
    import sensor_pkg::*;

    localparam int NUM_CASES  = 5;
    localparam int RESET_CLKS = 16;
    localparam int FIFO_BYTES = 96;

    typedef struct packed {
        fifo_ptr_t wr_ptr;
        fifo_ptr_t rd_ptr;
        fifo_ptr_t count;
    } case_row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        i_start;
    logic        sda_line;
    logic        scl;
    logic        dut_sda;
    logic        dut_sda_oe;
    logic        model_sda_low;
    sample_t     dut_sample;
    fifo_ptr_t   sample_count;
    logic        data_ready;

    case_row_t   rows [NUM_CASES];
    logic [7:0]  fifo_bytes [FIFO_BYTES];
    logic [23:0] got_data [$];
    fifo_ptr_t   got_index [$];
    int          ready_pulses = 0;
    int          check_errors = 0;
    int          timeouts = 0;
    int          cycles = 0;
    int          limit_cycles = 0;
    integer      seed = 32'hd6fa_1e8b;

    always #2 clk = ~clk;

    // pull-up, low when either side pulls down
    assign sda_line = !((dut_sda_oe && !dut_sda) || model_sda_low);

    sensor_reader_top sensor_reader_top_i (
        .clk            (clk),
        .reset          (reset),
        .i_start        (i_start),
        .i_sda          (sda_line),
        .o_scl          (scl),
        .o_sda          (dut_sda),
        .o_sda_oe       (dut_sda_oe),
        .o_sample       (dut_sample),
        .o_sample_count (sample_count),
        .o_data_ready   (data_ready)
    );

    sensor_model sensor_model_i (
        .i_scl     (scl),
        .i_sda     (sda_line),
        .o_sda_low (model_sda_low)
    );

    task automatic report_and_finish();
        int total;
        total = check_errors + sensor_model_i.bus_errors + timeouts;
        $display("errors: check %0d, bus %0d, timeout %0d",
                 check_errors, sensor_model_i.bus_errors, timeouts);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            check_errors++;
        end
    endtask

    // per cycle about 106 scl periods plus 27 per sample, doubled for margin
    function automatic int cycle_limit();
        int total;
        total = RESET_CLKS;
        for (int i = 0; i < NUM_CASES; i++) begin
            total += (110 + 27 * int'(rows[i].count)) * SCL_PERIOD_CLKS;
        end
        return 2 * total;
    endfunction

    // outputs sampled at the rising edge, before the DUT updates them
    always @(posedge clk) begin
        if (reset === 1'b0) begin
            if (dut_sample.valid === 1'b1) begin
                got_data.push_back(dut_sample.data);
                got_index.push_back(dut_sample.index);
            end
            if (data_ready === 1'b1) begin
                ready_pulses++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit_cycles > 0 && cycles > limit_cycles) begin
            $display("timeout: read cycle did not finish within %0d clock cycles", limit_cycles);
            timeouts++;
            report_and_finish();
        end
    end

    task automatic load_model(case_row_t row);
        sensor_model_i.wr_ptr = row.wr_ptr;
        sensor_model_i.rd_ptr = row.rd_ptr;
        for (int k = 0; k < FIFO_BYTES; k++) begin
            fifo_bytes[k] = 8'($random(seed));
            sensor_model_i.fifo_mem[k] = fifo_bytes[k];
        end
        sensor_model_i.ack_count  = 0;
        sensor_model_i.nack_count = 0;
        sensor_model_i.stop_count = 0;
        got_data.delete();
        got_index.delete();
        ready_pulses = 0;
    endtask

    task automatic run_cycle();
        @(negedge clk);
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        while (ready_pulses == 0) begin
            @(negedge clk);
        end
        // a couple of idle bit periods so stray strobes show up
        repeat (2 * SCL_PERIOD_CLKS) @(negedge clk);
    endtask

    task automatic check_case(int idx, case_row_t row);
        int          burst;
        int          n;
        logic [23:0] expected;
        burst = (row.count != '0) ? 1 : 0;
        n     = int'(row.count);
        compare_value($sformatf("case %0d sample count", idx), n, sample_count);
        compare_value($sformatf("case %0d sample strobes", idx), n, got_data.size());
        for (int j = 0; j < got_data.size() && j < n; j++) begin
            expected = {fifo_bytes[3 * j], fifo_bytes[3 * j + 1], fifo_bytes[3 * j + 2]};
            compare_value($sformatf("case %0d sample %0d data", idx, j), expected, got_data[j]);
            compare_value($sformatf("case %0d sample %0d index", idx, j), j, got_index[j]);
        end
        compare_value($sformatf("case %0d data ready pulses", idx), 1, ready_pulses);
        compare_value($sformatf("case %0d stop conditions", idx), 1, sensor_model_i.stop_count);
        compare_value($sformatf("case %0d master nacks", idx), 2 + burst,
                      sensor_model_i.nack_count);
        compare_value($sformatf("case %0d master acks", idx), 3 * n - burst,
                      sensor_model_i.ack_count);
    endtask

    initial begin
        case_row_t row;
        reset   = 1'b1;
        i_start = 1'b0;
        // write ptr, read ptr, expected count
        rows[0] = {5'd8, 5'd7, 5'd1};
        rows[1] = {5'd5, 5'd5, 5'd0};
        rows[2] = {5'd2, 5'd30, 5'd4};
        rows[3] = {5'd13, 5'd6, 5'd7};
        rows[4] = {5'd0, 5'd1, 5'd31};
        limit_cycles = cycle_limit();
        repeat (RESET_CLKS) @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < NUM_CASES; i++) begin
            row = rows[i];
            load_model(row);
            run_cycle();
            check_case(i, row);
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

/* tb/sensor_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_model (
    input  logic i_scl,
    input  logic i_sda,
    output logic o_sda_low
);
    import sensor_pkg::*;

    // log entries: bit 8 marks a bus condition, otherwise a byte from the master
    localparam logic [8:0] TOK_START = 9'h100;
    localparam logic [8:0] TOK_STOP  = 9'h101;

    typedef enum logic [1:0] {
        P_ADDR,
        P_REG,
        P_READ,
        P_IGNORE
    } phase_e;

    // loaded by the testbench before each cycle
    fifo_ptr_t  wr_ptr = '0;
    fifo_ptr_t  rd_ptr = '0;
    logic [7:0] fifo_mem [96];

    int ack_count  = 0;
    int nack_count = 0;
    int stop_count = 0;
    int bus_errors = 0;

    phase_e     phase      = P_IGNORE;
    phase_e     after_ack  = P_IGNORE;
    logic       active     = 1'b0;
    logic       master_ack = 1'b0;
    int         bit_idx    = 0;
    int         data_pos   = 0;
    logic [7:0] rx_byte    = '0;
    logic [7:0] tx_byte    = '0;
    logic [7:0] reg_addr   = '0;
    logic       scl_q      = 1'b1;
    logic       sda_q      = 1'b1;
    logic [8:0] log_q [$];

    initial begin
        o_sda_low = 1'b0;
    end

    function automatic logic [7:0] reg_value(logic [7:0] addr, int pos);
        case (addr)
            REG_FIFO_WR_PTR: return {3'b000, wr_ptr};
            REG_FIFO_RD_PTR: return {3'b000, rd_ptr};
            REG_FIFO_DATA:   return fifo_mem[pos];
            default:         return 8'h00;
        endcase
    endfunction

    // three groups of start, addr, reg, start, addr when samples wait, two otherwise
    function automatic logic [8:0] expected_token(int pos, int groups);
        logic [7:0] reg_sel;
        if (pos == 5 * groups) begin
            return TOK_STOP;
        end
        if (pos / 5 == 0) begin
            reg_sel = REG_FIFO_WR_PTR;
        end else if (pos / 5 == 1) begin
            reg_sel = REG_FIFO_RD_PTR;
        end else begin
            reg_sel = REG_FIFO_DATA;
        end
        case (pos % 5)
            0, 3:    return TOK_START;
            1:       return {1'b0, SENSOR_ADDR_WR};
            2:       return {1'b0, reg_sel};
            default: return {1'b0, SENSOR_ADDR_RD};
        endcase
    endfunction

    task automatic compare_log();
        fifo_ptr_t count;
        int        groups;
        count  = wr_ptr - rd_ptr;
        groups = (count != '0) ? 3 : 2;
        if (log_q.size() != 5 * groups + 1) begin
            $display("sensor model: bus cycle held %0d items where %0d were expected",
                     log_q.size(), 5 * groups + 1);
            bus_errors++;
        end else begin
            for (int i = 0; i < log_q.size(); i++) begin
                if (log_q[i] !== expected_token(i, groups)) begin
                    $display("sensor model: bus item %0d is %03h where %03h was expected",
                             i, log_q[i], expected_token(i, groups));
                    bus_errors++;
                    break;
                end
            end
        end
    endtask

    task automatic load_tx_byte();
        tx_byte = reg_value(reg_addr, data_pos);
        if (reg_addr == REG_FIFO_DATA) begin
            data_pos++;
        end
        o_sda_low = !tx_byte[7];
    endtask

    task automatic take_byte();
        log_q.push_back({1'b0, rx_byte});
        if (phase == P_ADDR) begin
            after_ack = (rx_byte == SENSOR_ADDR_RD) ? P_READ : P_REG;
        end else begin
            reg_addr  = rx_byte;
            after_ack = P_IGNORE;
            if (rx_byte == REG_FIFO_DATA) begin
                data_pos = 0;
            end
        end
    endtask

    task automatic rising_scl();
        bit_idx++;
        if ((phase == P_ADDR || phase == P_REG) && bit_idx <= 8) begin
            rx_byte = {rx_byte[6:0], i_sda};
            if (bit_idx == 8) begin
                take_byte();
            end
        end else if (phase == P_READ && bit_idx == 9) begin
            master_ack = !i_sda;
            if (master_ack) begin
                ack_count++;
            end else begin
                nack_count++;
            end
        end
    endtask

    task automatic falling_scl();
        if (phase == P_ADDR || phase == P_REG) begin
            if (bit_idx == 8) begin
                o_sda_low = 1'b1;
            end else if (bit_idx == 9) begin
                o_sda_low = 1'b0;
                bit_idx   = 0;
                phase     = after_ack;
                if (phase == P_READ) begin
                    load_tx_byte();
                end
            end
        end else if (phase == P_READ) begin
            if (bit_idx >= 1 && bit_idx <= 7) begin
                o_sda_low = !tx_byte[7 - bit_idx];
            end else if (bit_idx == 8) begin
                // master answers in the ack slot
                o_sda_low = 1'b0;
            end else if (bit_idx == 9) begin
                bit_idx = 0;
                if (master_ack) begin
                    load_tx_byte();
                end else begin
                    phase = P_IGNORE;
                end
            end
        end
    endtask

    task automatic bus_condition();
        if (active && bit_idx != 1) begin
            $display("sensor model: SDA changed while SCL was high in the middle of a byte");
            bus_errors++;
        end
        if (!i_sda) begin
            if (!active) begin
                log_q.delete();
            end
            active    = 1'b1;
            phase     = P_ADDR;
            bit_idx   = 0;
            o_sda_low = 1'b0;
            log_q.push_back(TOK_START);
        end else if (active) begin
            active    = 1'b0;
            phase     = P_IGNORE;
            bit_idx   = 0;
            o_sda_low = 1'b0;
            log_q.push_back(TOK_STOP);
            stop_count++;
            compare_log();
        end
    endtask

    always @(i_scl or i_sda) begin
        if (!$isunknown({i_scl, i_sda})) begin
            if (i_scl && scl_q && (i_sda != sda_q)) begin
                bus_condition();
            end else if (i_scl && !scl_q && active) begin
                rising_scl();
            end else if (!i_scl && scl_q && active) begin
                falling_scl();
            end
            scl_q = i_scl;
            sda_q = i_sda;
        end
    end

endmodule

`default_nettype wire

/* hw/sensor_reader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_reader_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_start,
    input  logic                  i_sda,
    output logic                  o_scl,
    output logic                  o_sda,
    output logic                  o_sda_oe,
    output sensor_pkg::sample_t   o_sample,
    output sensor_pkg::fifo_ptr_t o_sample_count,
    output logic                  o_data_ready
);
    import i2c_pkg::*;

    scl_phase_t phase;
    logic       scl_run;
    logic       bit_valid;
    bit_cmd_t   bit_cmd;
    logic       bit_done;
    logic       rx_bit;
    logic       byte_valid;
    byte_cmd_t  byte_cmd;
    logic       byte_done;
    i2c_byte_t  rx_byte;
    logic       rx_ack;
    logic       data_byte_valid;
    i2c_byte_t  data_byte;

    scl_timer scl_timer_i (
        .clk     (clk),
        .reset   (reset),
        .i_run   (scl_run),
        .o_scl   (o_scl),
        .o_phase (phase)
    );

    bit_engine bit_engine_i (
        .clk         (clk),
        .reset       (reset),
        .i_cmd_valid (bit_valid),
        .i_cmd       (bit_cmd),
        .i_phase     (phase),
        .i_sda       (i_sda),
        .o_scl_run   (scl_run),
        .o_done      (bit_done),
        .o_rx_bit    (rx_bit),
        .o_sda       (o_sda),
        .o_sda_oe    (o_sda_oe)
    );

    // slave ack is recorded only, never acted upon
    byte_engine byte_engine_i (
        .clk         (clk),
        .reset       (reset),
        .i_cmd_valid (byte_valid),
        .i_cmd       (byte_cmd),
        .i_bit_done  (bit_done),
        .i_rx_bit    (rx_bit),
        .o_bit_valid (bit_valid),
        .o_bit_cmd   (bit_cmd),
        .o_done      (byte_done),
        .o_rx_byte   (rx_byte),
        .o_rx_ack    (rx_ack)
    );

    fifo_sequencer fifo_sequencer_i (
        .clk               (clk),
        .reset             (reset),
        .i_start           (i_start),
        .i_byte_done       (byte_done),
        .i_rx_byte         (rx_byte),
        .o_cmd_valid       (byte_valid),
        .o_cmd             (byte_cmd),
        .o_data_byte_valid (data_byte_valid),
        .o_data_byte       (data_byte),
        .o_sample_count    (o_sample_count),
        .o_data_ready      (o_data_ready)
    );

    // index restarts once the previous cycle has finished
    sample_assembler sample_assembler_i (
        .clk           (clk),
        .reset         (reset),
        .i_byte_valid  (data_byte_valid),
        .i_byte        (data_byte),
        .i_cycle_start (o_data_ready),
        .o_sample      (o_sample)
    );

endmodule

`default_nettype wire

/* hw/sample_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_assembler (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_byte_valid,
    input  i2c_pkg::i2c_byte_t  i_byte,
    input  logic                i_cycle_start,
    output sensor_pkg::sample_t o_sample
);
    import sensor_pkg::*;

    logic [1:0]   byte_cnt;
    fifo_ptr_t    index;
    sample_data_t shift;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_cnt <= '0;
            index    <= '0;
            o_sample <= '0;
        end else begin
            o_sample.valid <= 1'b0;
            if (i_byte_valid) begin
                o_sample.data <= {shift[15:0], i_byte};
            end
            if (i_cycle_start) begin
                byte_cnt <= '0;
                index    <= '0;
            end else if (i_byte_valid) begin
                if (byte_cnt == 2'(BYTES_PER_SAMPLE - 1)) begin
                    byte_cnt       <= '0;
                    index          <= index + 5'd1;
                    o_sample.valid <= 1'b1;
                    o_sample.index <= index;
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

    // msb byte arrives first
    always_ff @(posedge clk) begin
        if (i_byte_valid) begin
            shift <= {shift[15:0], i_byte};
        end
    end

endmodule

`default_nettype wire

/* hw/fifo_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_start,
    input  logic                 i_byte_done,
    input  i2c_pkg::i2c_byte_t   i_rx_byte,
    output logic                 o_cmd_valid,
    output i2c_pkg::byte_cmd_t   o_cmd,
    output logic                 o_data_byte_valid,
    output i2c_pkg::i2c_byte_t   o_data_byte,
    output sensor_pkg::fifo_ptr_t o_sample_count,
    output logic                 o_data_ready
);
    import i2c_pkg::*;
    import sensor_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_ADDR_WR,
        S_REG,
        S_RSTART,
        S_ADDR_RD,
        S_READ,
        S_STOP
    } state_e;

    typedef enum logic [1:0] {
        T_WR_PTR,
        T_RD_PTR,
        T_DATA
    } txn_e;

    state_e     state;
    state_e     next_state;
    txn_e       txn;
    txn_e       next_txn;
    fifo_ptr_t  wr_ptr_q;
    fifo_ptr_t  count_calc;
    logic [6:0] bytes_left;
    logic [6:0] next_left;

    function automatic byte_cmd_t cmd_for(state_e st, txn_e tx, logic [6:0] left);
        byte_cmd_t c;
        c.op   = BYTE_WRITE;
        c.data = '0;
        c.ack  = 1'b0;
        case (st)
            S_START, S_RSTART: c.op = BYTE_START;
            S_ADDR_WR: c.data = SENSOR_ADDR_WR;
            S_REG: begin
                if (tx == T_WR_PTR) begin
                    c.data = REG_FIFO_WR_PTR;
                end else if (tx == T_RD_PTR) begin
                    c.data = REG_FIFO_RD_PTR;
                end else begin
                    c.data = REG_FIFO_DATA;
                end
            end
            S_ADDR_RD: c.data = SENSOR_ADDR_RD;
            // pointer reads are single bytes, so always NACKed
            S_READ: begin
                c.op  = BYTE_READ;
                c.ack = (tx == T_DATA) && (left != 7'd1);
            end
            default: c.op = BYTE_STOP;
        endcase
        return c;
    endfunction

    // received byte is the read pointer when this is used
    assign count_calc = wr_ptr_q - fifo_ptr_t'(i_rx_byte[4:0]);

    always_comb begin
        next_state = S_IDLE;
        next_txn   = txn;
        next_left  = bytes_left;
        case (state)
            S_START:   next_state = S_ADDR_WR;
            S_ADDR_WR: next_state = S_REG;
            S_REG:     next_state = S_RSTART;
            S_RSTART:  next_state = S_ADDR_RD;
            S_ADDR_RD: next_state = S_READ;
            S_READ: begin
                if (txn == T_WR_PTR) begin
                    next_txn   = T_RD_PTR;
                    next_state = S_START;
                end else if (txn == T_RD_PTR) begin
                    next_txn   = T_DATA;
                    next_left  = 7'(count_calc) * 7'(BYTES_PER_SAMPLE);
                    next_state = (count_calc == '0) ? S_STOP : S_START;
                end else begin
                    next_left  = bytes_left - 7'd1;
                    next_state = (bytes_left == 7'd1) ? S_STOP : S_READ;
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state             <= S_IDLE;
            txn               <= T_WR_PTR;
            bytes_left        <= '0;
            wr_ptr_q          <= '0;
            o_sample_count    <= '0;
            o_cmd_valid       <= 1'b0;
            o_data_byte_valid <= 1'b0;
            o_data_ready      <= 1'b0;
        end else begin
            o_cmd_valid       <= 1'b0;
            o_data_byte_valid <= 1'b0;
            o_data_ready      <= 1'b0;
            if (state == S_IDLE) begin
                if (i_start) begin
                    state       <= S_START;
                    txn         <= T_WR_PTR;
                    o_cmd_valid <= 1'b1;
                end
            end else if (i_byte_done) begin
                state      <= next_state;
                txn        <= next_txn;
                bytes_left <= next_left;
                if (state == S_READ) begin
                    case (txn)
                        T_WR_PTR: wr_ptr_q          <= fifo_ptr_t'(i_rx_byte[4:0]);
                        T_RD_PTR: o_sample_count    <= count_calc;
                        default:  o_data_byte_valid <= 1'b1;
                    endcase
                end
                if (next_state == S_IDLE) begin
                    o_data_ready <= 1'b1;
                end else begin
                    o_cmd_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            o_cmd <= cmd_for(S_START, T_WR_PTR, '0);
        end else if (i_byte_done) begin
            o_cmd       <= cmd_for(next_state, next_txn, next_left);
            o_data_byte <= i_rx_byte;
        end
    end

    a_one_cmd_in_flight: assert property (@(posedge clk) disable iff (reset)
        o_cmd_valid |=> (!o_cmd_valid until i_byte_done));

endmodule

`default_nettype wire

/* hw/byte_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_cmd_valid,
    input  i2c_pkg::byte_cmd_t i_cmd,
    input  logic               i_bit_done,
    input  logic               i_rx_bit,
    output logic               o_bit_valid,
    output i2c_pkg::bit_cmd_t  o_bit_cmd,
    output logic               o_done,
    output i2c_pkg::i2c_byte_t o_rx_byte,
    output logic               o_rx_ack
);
    import i2c_pkg::*;

    byte_op_e  op_q;
    i2c_byte_t shift;
    logic [3:0] bit_cnt;
    logic      ack_q;
    logic      busy;
    logic      last;

    // bit idx 0..7 carries data, idx 8 the ack slot
    function automatic bit_cmd_t bit_for(byte_op_e op, i2c_byte_t data, logic [3:0] idx,
                                         logic ack);
        bit_cmd_t c;
        c.op    = BIT_READ;
        c.value = 1'b1;
        case (op)
            BYTE_START: c.op = BIT_START;
            BYTE_STOP:  c.op = BIT_STOP;
            BYTE_WRITE: begin
                if (idx < 4'd8) begin
                    c.op    = BIT_WRITE;
                    c.value = data[7];
                end
            end
            default: begin
                if (idx == 4'd8) begin
                    c.op    = BIT_WRITE;
                    c.value = !ack;
                end
            end
        endcase
        return c;
    endfunction

    assign last   = (op_q inside {BYTE_START, BYTE_STOP}) || (bit_cnt == 4'd8);
    assign o_done = busy & i_bit_done & last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            op_q        <= BYTE_STOP;
            bit_cnt     <= '0;
            o_bit_valid <= 1'b0;
            o_rx_ack    <= 1'b1;
        end else begin
            o_bit_valid <= 1'b0;
            if (i_cmd_valid && !busy) begin
                busy        <= 1'b1;
                op_q        <= i_cmd.op;
                bit_cnt     <= '0;
                o_bit_valid <= 1'b1;
            end else if (busy && i_bit_done) begin
                if (last) begin
                    busy <= 1'b0;
                    if (op_q == BYTE_WRITE) begin
                        o_rx_ack <= i_rx_bit;
                    end
                end else begin
                    bit_cnt     <= bit_cnt + 4'd1;
                    o_bit_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmd_valid && !busy) begin
            shift     <= i_cmd.data;
            ack_q     <= i_cmd.ack;
            o_bit_cmd <= bit_for(i_cmd.op, i_cmd.data, 4'd0, i_cmd.ack);
        end else if (busy && i_bit_done && !last) begin
            shift     <= {shift[6:0], i_rx_bit};
            o_bit_cmd <= bit_for(op_q, {shift[6:0], i_rx_bit}, bit_cnt + 4'd1, ack_q);
            if (bit_cnt == 4'd7) begin
                o_rx_byte <= {shift[6:0], i_rx_bit};
            end
        end
    end

    a_no_cmd_busy: assert property (@(posedge clk) disable iff (reset)
        i_cmd_valid |-> !busy);

endmodule

`default_nettype wire

/* hw/bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_engine (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_cmd_valid,
    input  i2c_pkg::bit_cmd_t   i_cmd,
    input  i2c_pkg::scl_phase_t i_phase,
    input  logic                i_sda,
    output logic                o_scl_run,
    output logic                o_done,
    output logic                o_rx_bit,
    output logic                o_sda,
    output logic                o_sda_oe
);
    import i2c_pkg::*;

    bit_op_e op_q;
    logic    value_q;
    logic    busy;
    // bus owned from start until stop, keeps scl running between bits
    logic    hold;
    logic    scl_hi;

    assign o_scl_run = i_cmd_valid | busy | hold;
    assign o_done    = busy & i_phase.fall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            hold     <= 1'b0;
            op_q     <= BIT_STOP;
            value_q  <= 1'b1;
            o_sda    <= 1'b1;
            o_sda_oe <= 1'b0;
            o_rx_bit <= 1'b0;
            scl_hi   <= 1'b0;
        end else begin
            if (i_cmd_valid && !busy) begin
                busy    <= 1'b1;
                op_q    <= i_cmd.op;
                value_q <= i_cmd.value;
                if (i_cmd.op == BIT_START) begin
                    hold <= 1'b1;
                end
            end

            if (busy && i_phase.mid_low) begin
                case (op_q)
                    BIT_START: begin
                        o_sda_oe <= 1'b1;
                        o_sda    <= 1'b1;
                    end
                    BIT_STOP: begin
                        o_sda_oe <= 1'b1;
                        o_sda    <= 1'b0;
                    end
                    BIT_WRITE: begin
                        o_sda_oe <= 1'b1;
                        o_sda    <= value_q;
                    end
                    default: begin
                        o_sda_oe <= 1'b0;
                        o_sda    <= 1'b1;
                    end
                endcase
            end

            if (busy && i_phase.mid_high) begin
                case (op_q)
                    BIT_START: o_sda    <= 1'b0;
                    BIT_STOP:  o_sda    <= 1'b1;
                    BIT_READ:  o_rx_bit <= i_sda;
                    default:   o_rx_bit <= o_rx_bit;
                endcase
            end

            if (busy && i_phase.fall) begin
                busy <= 1'b0;
                if (op_q == BIT_STOP) begin
                    hold     <= 1'b0;
                    o_sda_oe <= 1'b0;
                end
            end

            if (i_phase.rise) begin
                scl_hi <= 1'b1;
            end else if (i_phase.fall) begin
                scl_hi <= 1'b0;
            end
        end
    end

    // data bits may only move while scl is low
    a_sda_stable_high: assert property (@(posedge clk) disable iff (reset)
        (scl_hi && $changed(o_sda_oe && !o_sda)) |-> (op_q inside {BIT_START, BIT_STOP}));

endmodule

`default_nettype wire

/* hw/scl_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module scl_timer (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_run,
    output logic                o_scl,
    output i2c_pkg::scl_phase_t o_phase
);
    import i2c_pkg::*;

    logic [4:0] cnt;
    logic [4:0] cnt_next;

    assign cnt_next = (cnt == 5'(SCL_PERIOD_CLKS - 1)) ? 5'd0 : cnt + 5'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt   <= '0;
            o_scl <= 1'b1;
        end else if (!i_run) begin
            cnt   <= '0;
            o_scl <= 1'b1;
        end else begin
            cnt   <= cnt_next;
            o_scl <= (cnt_next >= 5'(SCL_HALF_CLKS));
        end
    end

    // strobes mark the cycle before each edge or midpoint
    assign o_phase.mid_low  = i_run && (cnt == 5'(SCL_HALF_CLKS / 2 - 1));
    assign o_phase.rise     = i_run && (cnt == 5'(SCL_HALF_CLKS - 1));
    assign o_phase.mid_high = i_run && (cnt == 5'(SCL_HALF_CLKS + SCL_HALF_CLKS / 2 - 1));
    assign o_phase.fall     = i_run && (cnt == 5'(SCL_PERIOD_CLKS - 1));

endmodule

`default_nettype wire

/* hw/sensor_pkg.sv */
`default_nettype none

package sensor_pkg;

    localparam logic [7:0] SENSOR_ADDR_WR  = 8'hAE;
    localparam logic [7:0] SENSOR_ADDR_RD  = 8'hAF;
    localparam logic [7:0] REG_FIFO_WR_PTR = 8'h04;
    localparam logic [7:0] REG_FIFO_RD_PTR = 8'h06;
    localparam logic [7:0] REG_FIFO_DATA   = 8'h07;

    localparam int BYTES_PER_SAMPLE = 3;

    typedef logic [4:0]  fifo_ptr_t;
    typedef logic [23:0] sample_data_t;

    typedef struct packed {
        logic         valid;
        fifo_ptr_t    index;
        sample_data_t data;
    } sample_t;

endpackage

`default_nettype wire

/* hw/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    // scl timing in system clocks
    localparam int SCL_HALF_CLKS   = 10;
    localparam int SCL_PERIOD_CLKS = 20;

    typedef logic [7:0] i2c_byte_t;

    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    value;
    } bit_cmd_t;

    typedef enum logic [1:0] {
        BYTE_START,
        BYTE_STOP,
        BYTE_WRITE,
        BYTE_READ
    } byte_op_e;

    // ack = 1 sends ACK after a read byte, 0 sends NACK
    typedef struct packed {
        byte_op_e  op;
        i2c_byte_t data;
        logic      ack;
    } byte_cmd_t;

    typedef struct packed {
        logic rise;
        logic fall;
        logic mid_high;
        logic mid_low;
    } scl_phase_t;

endpackage

`default_nettype wire
